// ==== hw/fetch_ctrl_pkg.sv ====
package fetch_ctrl_pkg;

  ////////////////////
  // Redirect sources
  ////////////////////

  // Source of the next fetch address when a redirect is requested
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5
  } pc_mux_e;

  ////////////////////
  // Trap addressing
  ////////////////////

  // Trap base field taken from mtvec
  localparam int unsigned MTVEC_W = 25;

  // Zero bits appended below the trap base
  localparam int unsigned TRAP_OFFS_W = 32 - MTVEC_W;

  // Interrupt number width
  // Vector slots sit one word apart above the trap base
  localparam int unsigned IRQ_ID_W = 5;

  ////////////////////
  // Sequential fetch
  ////////////////////

  // Address step between consecutive fetches in bytes
  localparam logic [31:0] FETCH_STEP = 32'd4;

endpackage

// ==== hw/instr_bus_pkg.sv ====
package instr_bus_pkg;

  ////////////////////
  // Bus widths
  ////////////////////

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  ////////////////////
  // Response payload
  ////////////////////

  // Fetched word together with the bus error flag
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } instr_resp_t;

  // Empty response
  localparam instr_resp_t INSTR_RESP_RESET = '{rdata: '0, err: 1'b0};

endpackage

// ==== hw/pc_select.sv ====
`timescale 1ns/1ps

module pc_select import fetch_ctrl_pkg::*; (
  // Redirect request and source
  input  pc_mux_e              pc_mux_i,
  input  logic                 pc_set_i,

  // Candidate targets
  input  logic [31:0]          boot_addr_i,
  input  logic [31:0]          jump_target_i,
  input  logic [31:0]          branch_target_i,
  input  logic [31:0]          mepc_i,
  input  logic [MTVEC_W-1:0]   mtvec_addr_i,
  input  logic [IRQ_ID_W-1:0]  irq_id_i,

  // Word aligned fetch target
  output logic [31:0]          branch_addr_o,
  // Tells the CSR file to set up mtvec
  output logic                 csr_mtvec_init_o
);

  // Raw target before word alignment
  logic [31:0] target;

  ////////////////////
  // Target mux
  ////////////////////

  always_comb begin
    // Boot address unless a source below matches
    target = boot_addr_i;
    case (pc_mux_i)
      PC_BOOT:     target = boot_addr_i;
      PC_JUMP:     target = jump_target_i;
      PC_BRANCH:   target = branch_target_i;
      // Return to the interrupted instruction
      PC_MRET:     target = mepc_i;
      // All exceptions share the trap base
      PC_TRAP_EXC: target = {mtvec_addr_i, {TRAP_OFFS_W{1'b0}}};
      // Vectored interrupts land one word per interrupt number above the base
      PC_TRAP_IRQ: target = {mtvec_addr_i, irq_id_i, {(TRAP_OFFS_W - IRQ_ID_W){1'b0}}};
      default:     target = boot_addr_i;
    endcase
  end

  // Only 32-bit words are fetched
  assign branch_addr_o = {target[31:2], 2'b00};

  // One pulse per boot redirect
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

endmodule

// ==== hw/fetch_bus_master.sv ====
`timescale 1ns/1ps

module fetch_bus_master import fetch_ctrl_pkg::*, instr_bus_pkg::*; #(
  parameter int unsigned FIFO_DEPTH = 2,
  parameter int unsigned CNT_W      = 2
) (
  input  logic              clk,
  input  logic              rst_n,

  // Redirect
  input  logic              pc_set_i,
  input  logic [ADDR_W-1:0] branch_addr_i,

  // Prefetch FIFO fill level
  input  logic [CNT_W-1:0]  fifo_cnt_i,

  // Instruction bus
  output logic              instr_req_o,
  output logic [ADDR_W-1:0] instr_addr_o,
  input  logic              instr_gnt_i,
  input  logic              instr_rvalid_i,
  input  logic [DATA_W-1:0] instr_rdata_i,
  input  logic              instr_err_i,

  // Push into the prefetch FIFO
  output logic              push_valid_o,
  output instr_resp_t       push_data_o,
  output logic [ADDR_W-1:0] push_addr_o
);

  localparam int unsigned PTR_W        = $clog2(FIFO_DEPTH);
  // Stale responses may pile up over several quick redirects
  localparam int unsigned DISC_W       = CNT_W + 2;
  localparam int unsigned INFLIGHT_MAX = (1 << DISC_W) - 1;

  logic              fetch_active_q;
  logic [ADDR_W-1:0] addr_q;
  logic              redir_pend_q;
  logic [ADDR_W-1:0] redir_addr_q;
  logic [CNT_W-1:0]  outstnd_q;
  logic [DISC_W-1:0] discard_q;
  logic [ADDR_W-1:0] aq_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  aq_wr_q;
  logic [PTR_W-1:0]  aq_rd_q;

  logic has_room;
  logic below_cap;
  logic grant;
  logic req_wait;
  logic grant_stale;
  logic grant_live;
  logic drop_rsp;
  logic live_rsp;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////
  // Address phase
  ////////////////////

  // Every live request needs a free FIFO entry when it returns
  assign has_room  = (int'(outstnd_q) + int'(fifo_cnt_i)) < FIFO_DEPTH;
  // Cap on everything still on the bus, stale or live
  assign below_cap = (int'(discard_q) + int'(outstnd_q)) < INFLIGHT_MAX;

  assign instr_req_o  = fetch_active_q && has_room && below_cap;
  assign instr_addr_o = addr_q;

  assign grant    = instr_req_o && instr_gnt_i;
  assign req_wait = instr_req_o && !instr_gnt_i;

  // Grant of an old address while a redirect is taken or parked
  assign grant_stale = grant && (pc_set_i || redir_pend_q);
  assign grant_live  = grant && !grant_stale;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_active_q <= 1'b0;
      addr_q         <= '0;
      redir_pend_q   <= 1'b0;
    end else if (pc_set_i) begin
      // First redirect starts fetching
      fetch_active_q <= 1'b1;
      // A request waiting for gnt keeps its address
      redir_pend_q   <= req_wait;
      if (!req_wait) begin
        addr_q <= branch_addr_i;
      end
    end else if (grant) begin
      redir_pend_q <= 1'b0;
      addr_q       <= redir_pend_q ? redir_addr_q : addr_q + FETCH_STEP;
    end
  end

  // Parked redirect target
  always_ff @(posedge clk) begin
    if (pc_set_i) begin
      redir_addr_q <= branch_addr_i;
    end
  end

  ////////////////////
  // Response phase
  ////////////////////

  // Responses come back in order so stale ones come first
  assign drop_rsp = instr_rvalid_i && (discard_q != '0);
  assign live_rsp = instr_rvalid_i && (discard_q == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstnd_q <= '0;
      discard_q <= '0;
    end else if (pc_set_i) begin
      // Live requests left on the bus turn stale
      outstnd_q <= '0;
      discard_q <= discard_q + DISC_W'(outstnd_q) + DISC_W'(grant_stale)
                   - DISC_W'(drop_rsp) - DISC_W'(live_rsp);
    end else begin
      outstnd_q <= outstnd_q + CNT_W'(grant_live) - CNT_W'(live_rsp);
      discard_q <= discard_q + DISC_W'(grant_stale) - DISC_W'(drop_rsp);
    end
  end

  // Addresses of live requests in bus order
  always_ff @(posedge clk) begin
    if (grant_live) begin
      aq_mem[aq_wr_q] <= addr_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aq_wr_q <= '0;
      aq_rd_q <= '0;
    end else if (pc_set_i) begin
      // New stream starts with an empty queue
      aq_rd_q <= aq_wr_q;
    end else begin
      if (grant_live) begin
        aq_wr_q <= ptr_inc(aq_wr_q);
      end
      if (live_rsp) begin
        aq_rd_q <= ptr_inc(aq_rd_q);
      end
    end
  end

  // Word goes to the FIFO tagged with its own PC
  assign push_valid_o = live_rsp;
  assign push_data_o  = '{rdata: instr_rdata_i, err: instr_err_i};
  assign push_addr_o  = aq_mem[aq_rd_q];

endmodule

// ==== hw/prefetch_fifo.sv ====
`timescale 1ns/1ps

module prefetch_fifo import instr_bus_pkg::*; #(
  parameter int unsigned FIFO_DEPTH = 2,
  parameter int unsigned CNT_W      = 2
) (
  input  logic              clk,
  input  logic              rst_n,

  // Redirect empties the buffer
  input  logic              flush_i,

  // Write side from the bus master
  input  logic              push_valid_i,
  input  instr_resp_t       push_data_i,
  input  logic [ADDR_W-1:0] push_addr_i,

  // Read side towards IF/ID
  input  logic              pop_ready_i,
  output logic              pop_valid_o,
  output instr_resp_t       pop_data_o,
  output logic [ADDR_W-1:0] pop_addr_o,

  // Fill level
  output logic [CNT_W-1:0]  cnt_o
);

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

  instr_resp_t       data_mem [FIFO_DEPTH];
  logic [ADDR_W-1:0] addr_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_q;
  logic [PTR_W-1:0]  rd_q;
  logic [CNT_W-1:0]  cnt_q;

  logic push;
  logic pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Words arriving during a flush belong to the old stream
  assign push = push_valid_i && !flush_i;

  // Head is hidden during a flush
  assign pop_valid_o = (cnt_q != '0) && !flush_i;
  assign pop         = pop_valid_o && pop_ready_i;

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      data_mem[wr_q] <= push_data_i;
      addr_mem[wr_q] <= push_addr_i;
    end
  end

  assign pop_data_o = data_mem[rd_q];
  assign pop_addr_o = addr_mem[rd_q];

  ////////////////////
  // Pointers
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_q  <= '0;
      rd_q  <= '0;
      cnt_q <= '0;
    end else if (flush_i) begin
      wr_q  <= '0;
      rd_q  <= '0;
      cnt_q <= '0;
    end else begin
      if (push) begin
        wr_q <= ptr_inc(wr_q);
      end
      if (pop) begin
        rd_q <= ptr_inc(rd_q);
      end
      // master bounds requests so this never overflows
      cnt_q <= cnt_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  assign cnt_o = cnt_q;

endmodule

// ==== hw/if_id_pipe_reg.sv ====
`timescale 1ns/1ps

module if_id_pipe_reg import instr_bus_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,

  // Control
  input  logic              flush_i,
  input  logic              halt_i,

  // From the prefetch FIFO
  input  logic              in_valid_i,
  input  instr_resp_t       in_data_i,
  input  logic [ADDR_W-1:0] in_addr_i,
  output logic              in_ready_o,

  // To ID
  input  logic              id_ready_i,
  output logic              if_id_valid_o,
  output logic [DATA_W-1:0] if_id_instr_o,
  output logic [ADDR_W-1:0] if_id_pc_o,
  output logic              if_id_err_o
);

  logic              valid_q;
  instr_resp_t       data_q;
  logic [ADDR_W-1:0] pc_q;
  logic              load;

  // Take a word when not halted and the stage is empty or draining
  assign in_ready_o = !halt_i && (!valid_q || id_ready_i);
  assign load       = in_valid_i && in_ready_o;

  ////////////////////
  // Valid flag
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      // Redirect kills the word in IF/ID
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (id_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  ////////////////////
  // Payload
  ////////////////////

  // Held unchanged while ID stalls
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_q <= INSTR_RESP_RESET;
      pc_q   <= '0;
    end else if (load) begin
      data_q <= in_data_i;
      pc_q   <= in_addr_i;
    end
  end

  assign if_id_valid_o = valid_q;
  assign if_id_instr_o = data_q.rdata;
  assign if_id_err_o   = data_q.err;
  assign if_id_pc_o    = pc_q;

endmodule

// ==== hw/if_stage.sv ====
`timescale 1ns/1ps

module if_stage import fetch_ctrl_pkg::*, instr_bus_pkg::*; #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                clk,
  input  logic                rst_n,

  // Redirect control
  input  logic                pc_set_i,
  input  pc_mux_e             pc_mux_i,
  input  logic [31:0]         boot_addr_i,
  input  logic [31:0]         jump_target_i,
  input  logic [31:0]         branch_target_i,
  input  logic [31:0]         mepc_i,
  input  logic [MTVEC_W-1:0]  mtvec_addr_i,
  input  logic [IRQ_ID_W-1:0] irq_id_i,
  input  logic                halt_if_i,
  output logic                csr_mtvec_init_o,

  // Instruction bus
  output logic                instr_req_o,
  output logic [ADDR_W-1:0]   instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  logic [DATA_W-1:0]   instr_rdata_i,
  input  logic                instr_err_i,

  // IF/ID handshake
  output logic                if_id_valid_o,
  output logic [DATA_W-1:0]   if_id_instr_o,
  output logic [ADDR_W-1:0]   if_id_pc_o,
  output logic                if_id_err_o,
  input  logic                id_ready_i
);

  // Counter holds 0 to FIFO_DEPTH
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [ADDR_W-1:0] branch_addr;
  logic              push_valid;
  instr_resp_t       push_data;
  logic [ADDR_W-1:0] push_addr;
  logic [CNT_W-1:0]  fifo_cnt;
  logic              pop_valid;
  logic              pop_ready;
  instr_resp_t       pop_data;
  logic [ADDR_W-1:0] pop_addr;

  ////////////////////
  // Next PC
  ////////////////////

  pc_select i_pc_select (
    .pc_mux_i         (pc_mux_i),
    .pc_set_i         (pc_set_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .irq_id_i         (irq_id_i),
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  ////////////////////
  // Prefetcher
  ////////////////////

  fetch_bus_master #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .CNT_W      (CNT_W)
  ) i_fetch_bus_master (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_set_i       (pc_set_i),
    .branch_addr_i  (branch_addr),
    .fifo_cnt_i     (fifo_cnt),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .push_valid_o   (push_valid),
    .push_data_o    (push_data),
    .push_addr_o    (push_addr)
  );

  prefetch_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .CNT_W      (CNT_W)
  ) i_prefetch_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (pc_set_i),
    .push_valid_i (push_valid),
    .push_data_i  (push_data),
    .push_addr_i  (push_addr),
    .pop_ready_i  (pop_ready),
    .pop_valid_o  (pop_valid),
    .pop_data_o   (pop_data),
    .pop_addr_o   (pop_addr),
    .cnt_o        (fifo_cnt)
  );

  ////////////////////
  // IF/ID register
  ////////////////////

  if_id_pipe_reg i_if_id_pipe_reg (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (pc_set_i),
    .halt_i        (halt_if_i),
    .in_valid_i    (pop_valid),
    .in_data_i     (pop_data),
    .in_addr_i     (pop_addr),
    .in_ready_o    (pop_ready),
    .id_ready_i    (id_ready_i),
    .if_id_valid_o (if_id_valid_o),
    .if_id_instr_o (if_id_instr_o),
    .if_id_pc_o    (if_id_pc_o),
    .if_id_err_o   (if_id_err_o)
  );

endmodule

// ==== bench/if_stage_chk.sv ====
`timescale 1ns/1ps

module if_stage_chk (
  input logic        clk,
  input logic        rst_n,
  input logic        pc_set_i,
  input logic        instr_req_i,
  input logic        instr_gnt_i,
  input logic [31:0] instr_addr_i,
  input logic        if_id_valid_i,
  input logic        id_ready_i,
  input logic [31:0] if_id_instr_i,
  input logic [31:0] if_id_pc_i,
  input logic        if_id_err_i
);

  // Failed assertions so far, read by the testbench
  int unsigned fail_cnt = 0;

  // Set by the first redirect after reset
  logic seen_set_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_set_q <= 1'b0;
    end else if (pc_set_i) begin
      seen_set_q <= 1'b1;
    end
  end

  ////////////////////
  // Bus handshake
  ////////////////////

  // Waiting request keeps req and address until granted
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_i && !instr_gnt_i |=> instr_req_i && $stable(instr_addr_i))
  else begin
    $error("instruction request dropped or address moved before grant");
    fail_cnt++;
  end

  // Fetch stays idle until the first redirect
  a_no_early_req: assert property (@(posedge clk) disable iff (!rst_n)
    !seen_set_q |-> !instr_req_i)
  else begin
    $error("instruction request issued before the first redirect");
    fail_cnt++;
  end

  ////////////////////
  // IF/ID handshake
  ////////////////////

  // Stalled word stays put unless a redirect kills it
  a_if_id_hold: assert property (@(posedge clk) disable iff (!rst_n)
    if_id_valid_i && !id_ready_i && !pc_set_i |=>
      if_id_valid_i && $stable(if_id_instr_i) && $stable(if_id_pc_i) && $stable(if_id_err_i))
  else begin
    $error("IF/ID output changed while ID was stalled");
    fail_cnt++;
  end

endmodule

bind if_stage if_stage_chk i_if_stage_chk (
  .clk           (clk),
  .rst_n         (rst_n),
  .pc_set_i      (pc_set_i),
  .instr_req_i   (instr_req_o),
  .instr_gnt_i   (instr_gnt_i),
  .instr_addr_i  (instr_addr_o),
  .if_id_valid_i (if_id_valid_o),
  .id_ready_i    (id_ready_i),
  .if_id_instr_i (if_id_instr_o),
  .if_id_pc_i    (if_id_pc_o),
  .if_id_err_i   (if_id_err_o)
);

// ==== bench/if_stage_scoreboard.sv ====
`timescale 1ns/1ps

module if_stage_scoreboard import fetch_ctrl_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,

  // Redirect as seen by the DUT
  input  logic                pc_set_i,
  input  pc_mux_e             pc_mux_i,
  input  logic [31:0]         boot_addr_i,
  input  logic [31:0]         jump_target_i,
  input  logic [31:0]         branch_target_i,
  input  logic [31:0]         mepc_i,
  input  logic [MTVEC_W-1:0]  mtvec_addr_i,
  input  logic [IRQ_ID_W-1:0] irq_id_i,
  input  logic                csr_mtvec_init_i,

  // IF/ID handshake
  input  logic                if_id_valid_i,
  input  logic [31:0]         if_id_instr_i,
  input  logic [31:0]         if_id_pc_i,
  input  logic                if_id_err_i,
  input  logic                id_ready_i,

  // Transfers since the last redirect and mismatches so far
  output int unsigned         xfer_cnt_o,
  output int unsigned         err_cnt_o
);

  logic        started_q;
  logic [31:0] exp_pc_q;

  // Target of a redirect, word aligned
  function automatic logic [31:0] redirect_target(input pc_mux_e src);
    logic [31:0] base;
    logic [31:0] addr;
    // Trap base is the mtvec field shifted above seven zero bits
    base = 32'(mtvec_addr_i) << 7;
    case (src)
      PC_JUMP:     addr = jump_target_i;
      PC_BRANCH:   addr = branch_target_i;
      PC_MRET:     addr = mepc_i;
      PC_TRAP_EXC: addr = base;
      PC_TRAP_IRQ: addr = base + 32'(irq_id_i) * 4;
      default:     addr = boot_addr_i;
    endcase
    return addr & ~32'h3;
  endfunction

  // Memory content at a fetch address
  function automatic logic [31:0] expected_word(input logic [31:0] pc);
    return {pc[15:0], pc[31:16]} ^ 32'h9E37_79B9 ^ (pc << 3);
  endfunction

  always @(posedge clk or negedge rst_n) begin : compare
    int unsigned errs;
    logic [31:0] exp_word;
    logic        exp_err;
    if (!rst_n) begin
      started_q  <= 1'b0;
      exp_pc_q   <= '0;
      xfer_cnt_o <= 0;
      err_cnt_o  <= 0;
    end else begin
      errs     = 0;
      exp_word = expected_word(exp_pc_q);
      exp_err  = (exp_pc_q[11:8] == 4'hF);
      // Init pulse only with a boot redirect
      if (csr_mtvec_init_i !== (pc_set_i && pc_mux_i == PC_BOOT)) begin
        $display("CHECK FAILED %0t ns: csr_mtvec_init %b with pc_set %b source %s",
                 $time, csr_mtvec_init_i, pc_set_i, pc_mux_i.name());
        errs++;
      end
      if (if_id_valid_i && id_ready_i) begin
        if (!started_q) begin
          $display("CHECK FAILED %0t ns: transfer at pc %h before any redirect",
                   $time, if_id_pc_i);
          errs++;
        end else if (if_id_pc_i !== exp_pc_q) begin
          $display("CHECK FAILED %0t ns: pc %h expected %h", $time, if_id_pc_i, exp_pc_q);
          errs++;
        end else if (if_id_instr_i !== exp_word || if_id_err_i !== exp_err) begin
          $display("CHECK FAILED %0t ns: pc %h word %h err %b expected %h err %b",
                   $time, if_id_pc_i, if_id_instr_i, if_id_err_i, exp_word, exp_err);
          errs++;
        end
        // Resync on the DUT stream so one slip is reported once
        exp_pc_q   <= if_id_pc_i + 32'd4;
        xfer_cnt_o <= xfer_cnt_o + 1;
      end
      // Redirect starts a new expected stream
      if (pc_set_i) begin
        started_q  <= 1'b1;
        exp_pc_q   <= redirect_target(pc_mux_i);
        xfer_cnt_o <= 0;
      end
      err_cnt_o <= err_cnt_o + errs;
    end
  end

endmodule

// ==== bench/tb_if_stage.sv ====
`timescale 1ns/1ps

module tb_if_stage import fetch_ctrl_pkg::*;;

  localparam int unsigned NUM_TESTS       = 24;
  localparam int unsigned WORDS_PER_TEST  = 8;
  localparam int unsigned MAX_QUICK       = 2;
  // Generous bound on cycles per redirect or word
  localparam int unsigned CYCLES_PER_STEP = 40;
  localparam int unsigned CYCLE_LIMIT     =
    NUM_TESTS * (MAX_QUICK + 1 + WORDS_PER_TEST) * CYCLES_PER_STEP + 100;

  logic                clk;
  logic                rst_n;
  logic                pc_set_i;
  pc_mux_e             pc_mux_i;
  logic [31:0]         boot_addr_i;
  logic [31:0]         jump_target_i;
  logic [31:0]         branch_target_i;
  logic [31:0]         mepc_i;
  logic [MTVEC_W-1:0]  mtvec_addr_i;
  logic [IRQ_ID_W-1:0] irq_id_i;
  logic                halt_if_i;
  logic                csr_mtvec_init_o;
  logic                instr_req_o;
  logic [31:0]         instr_addr_o;
  logic                instr_gnt_i;
  logic                instr_rvalid_i;
  logic [31:0]         instr_rdata_i;
  logic                instr_err_i;
  logic                if_id_valid_o;
  logic [31:0]         if_id_instr_o;
  logic [31:0]         if_id_pc_o;
  logic                if_id_err_o;
  logic                id_ready_i;

  int unsigned cycle_cnt;
  int unsigned xfer_cnt;
  int unsigned sb_err_cnt;

  // Granted addresses and the cycle each answer is due
  logic [31:0] rsp_addr_q[$];
  int unsigned rsp_due_q[$];

  if_stage #(
    .FIFO_DEPTH (2)
  ) i_if_stage (
    .clk              (clk),
    .rst_n            (rst_n),
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .irq_id_i         (irq_id_i),
    .halt_if_i        (halt_if_i),
    .csr_mtvec_init_o (csr_mtvec_init_o),
    .instr_req_o      (instr_req_o),
    .instr_addr_o     (instr_addr_o),
    .instr_gnt_i      (instr_gnt_i),
    .instr_rvalid_i   (instr_rvalid_i),
    .instr_rdata_i    (instr_rdata_i),
    .instr_err_i      (instr_err_i),
    .if_id_valid_o    (if_id_valid_o),
    .if_id_instr_o    (if_id_instr_o),
    .if_id_pc_o       (if_id_pc_o),
    .if_id_err_o      (if_id_err_o),
    .id_ready_i       (id_ready_i)
  );

  if_stage_scoreboard i_scoreboard (
    .clk              (clk),
    .rst_n            (rst_n),
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .irq_id_i         (irq_id_i),
    .csr_mtvec_init_i (csr_mtvec_init_o),
    .if_id_valid_i    (if_id_valid_o),
    .if_id_instr_i    (if_id_instr_o),
    .if_id_pc_i       (if_id_pc_o),
    .if_id_err_i      (if_id_err_o),
    .id_ready_i       (id_ready_i),
    .xfer_cnt_o       (xfer_cnt),
    .err_cnt_o        (sb_err_cnt)
  );

  // Scrambled memory word at an address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h9E37_79B9 ^ (addr << 3);
  endfunction

  // Random target, often close to the error window at 0x?F00
  function automatic logic [31:0] rand_target();
    logic [31:0] val;
    val = $urandom;
    if ($urandom_range(0, 3) == 0) begin
      val[11:4] = 8'hFF;
    end
    return val;
  endfunction

  // Mismatches from the scoreboard plus failed assertions
  function automatic int unsigned total_errors();
    return sb_err_cnt + i_if_stage.i_if_stage_chk.fail_cnt;
  endfunction

  always #10 clk = ~clk;

  ////////////////////
  // Bus slave model
  ////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      instr_gnt_i <= ($urandom_range(0, 2) != 0);
      if (instr_req_o && instr_gnt_i) begin
        rsp_addr_q.push_back(instr_addr_o);
        rsp_due_q.push_back(cycle_cnt + $urandom_range(1, 4));
      end
      // In order, one answer per cycle
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle_cnt) begin
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= mem_word(rsp_addr_q[0]);
        instr_err_i    <= (rsp_addr_q[0][11:8] == 4'hF);
        rsp_addr_q.pop_front();
        rsp_due_q.pop_front();
      end else begin
        instr_rvalid_i <= 1'b0;
        instr_rdata_i  <= '0;
        instr_err_i    <= 1'b0;
      end
    end
  end

  // ID back-pressure and halt
  always @(posedge clk) begin
    if (rst_n) begin
      id_ready_i <= ($urandom_range(0, 3) != 0);
      halt_if_i  <= ($urandom_range(0, 7) == 0);
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // One-cycle redirect with fresh random targets
  task automatic redirect(input pc_mux_e src);
    @(posedge clk);
    pc_set_i        <= 1'b1;
    pc_mux_i        <= src;
    boot_addr_i     <= rand_target();
    jump_target_i   <= rand_target();
    branch_target_i <= rand_target();
    mepc_i          <= rand_target();
    mtvec_addr_i    <= MTVEC_W'($urandom);
    irq_id_i        <= IRQ_ID_W'($urandom);
    @(posedge clk);
    pc_set_i <= 1'b0;
  endtask

  task automatic wait_words(input int unsigned words);
    do begin
      @(posedge clk);
    end while (xfer_cnt < words);
  endtask

  initial begin
    int unsigned n_quick;
    int unsigned err_before;
    int unsigned n_pass;
    int unsigned n_fail;
    pc_mux_e     src;
    void'($urandom(32'h2032));
    n_pass          = 0;
    n_fail          = 0;
    clk             = 1'b0;
    rst_n           = 1'b0;
    cycle_cnt       = 0;
    pc_set_i        = 1'b0;
    pc_mux_i        = PC_BOOT;
    boot_addr_i     = '0;
    jump_target_i   = '0;
    branch_target_i = '0;
    mepc_i          = '0;
    mtvec_addr_i    = '0;
    irq_id_i        = '0;
    halt_if_i       = 1'b0;
    id_ready_i      = 1'b0;
    instr_gnt_i     = 1'b0;
    instr_rvalid_i  = 1'b0;
    instr_rdata_i   = '0;
    instr_err_i     = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) @(posedge clk);
    for (int t = 0; t < NUM_TESTS; t++) begin
      err_before = total_errors();
      // First six tests walk every source, boot first
      src     = (t < 6) ? pc_mux_e'(t) : pc_mux_e'($urandom_range(0, 5));
      n_quick = (t == 0) ? 0 : $urandom_range(0, MAX_QUICK);
      // Redirects that leave stale requests on the bus
      for (int q = 0; q < n_quick; q++) begin
        redirect(pc_mux_e'($urandom_range(0, 5)));
        repeat ($urandom_range(0, 3)) @(posedge clk);
      end
      redirect(src);
      wait_words(WORDS_PER_TEST);
      if (total_errors() == err_before) begin
        n_pass++;
      end else begin
        n_fail++;
      end
      $display("test %0d: source %s after %0d quick redirects, %0d words, %s",
               t, src.name(), n_quick, WORDS_PER_TEST,
               (total_errors() == err_before) ? "pass" : "fail");
    end
    repeat (4) @(posedge clk);
    $display("summary: %0d tests, %0d passed, %0d failed, %0d mismatches, %0d assertion failures",
             NUM_TESTS, n_pass, n_fail, sb_err_cnt, i_if_stage.i_if_stage_chk.fail_cnt);
    if (total_errors() == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
hw/fetch_ctrl_pkg.sv
hw/instr_bus_pkg.sv
hw/pc_select.sv
hw/fetch_bus_master.sv
hw/prefetch_fifo.sv
hw/if_id_pipe_reg.sv
hw/if_stage.sv
bench/if_stage_chk.sv
bench/if_stage_scoreboard.sv
bench/tb_if_stage.sv
